// ==== dv/eth_mac_tx_tb.sv ====
`timescale 1ns/10ps

module eth_mac_tx_tb;
    import eth_frame_pkg::*;
    import eth_tx_cfg_pkg::*;

    localparam int MAX_FRAMES = 16;
    localparam int PAT_WORDS  = 256;

    // dut ports
    logic        i_clk;
    logic        i_rst;
    logic        i_s_valid;
    logic        o_s_ready;
    byte_t       i_s_data;
    logic        i_s_last;
    ether_type_t i_s_type;
    mac_addr_t   i_dst_mac;
    logic        i_dst_mac_valid;
    mac_addr_t   i_src_mac;
    logic        i_src_mac_valid;
    ipg_t        i_ipg;
    logic        i_ipg_valid;
    logic        o_m_valid;
    logic        i_m_ready;
    byte_t       o_m_data;
    logic        o_m_last;
    frame_cnt_t  o_frame_cnt;

    // pattern words and per-frame view of them
    logic [63:0] pat_mem [0:PAT_WORDS-1];
    int          nframes;
    int          f_len [0:MAX_FRAMES-1];
    int          f_pay [0:MAX_FRAMES-1];
    int          f_gap [0:MAX_FRAMES-1];
    int          f_end [0:MAX_FRAMES-1];
    logic [7:0]  f_flags [0:MAX_FRAMES-1];
    ether_type_t f_type [0:MAX_FRAMES-1];

    // expected wire bytes of all frames in order
    byte_t exp_q [$];
    fcs_t  run_crc;

    // monitor and run state
    int     mon_frame;
    int     exp_idx;
    int     pos_in_frame;
    int     idle_cnt;
    logic   prev_stall;
    byte_t  prev_data;
    logic   prev_last;
    logic   cnt_pending;
    int     cycles;
    int     limit;
    integer seed;

    eth_mac_tx u_eth_mac_tx
    (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_s_valid       (i_s_valid),
        .o_s_ready       (o_s_ready),
        .i_s_data        (i_s_data),
        .i_s_last        (i_s_last),
        .i_s_type        (i_s_type),
        .i_dst_mac       (i_dst_mac),
        .i_dst_mac_valid (i_dst_mac_valid),
        .i_src_mac       (i_src_mac),
        .i_src_mac_valid (i_src_mac_valid),
        .i_ipg           (i_ipg),
        .i_ipg_valid     (i_ipg_valid),
        .o_m_valid       (o_m_valid),
        .i_m_ready       (i_m_ready),
        .o_m_data        (o_m_data),
        .o_m_last        (o_m_last),
        .o_frame_cnt     (o_frame_cnt)
    );

    // 100 ns clock
    always
    begin
        #50 i_clk = ~i_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    // reflected crc-32 over one octet
    function automatic fcs_t crc_byte(input fcs_t c, input byte_t d);
        fcs_t r;
        r = c ^ {24'h0, d};
        for (int k = 0; k < 8; k++)
        begin
            r = r[0] ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
        end
        return r;
    endfunction

    // append one wire byte and fold it into the fcs when covered
    task automatic emit(input byte_t b, input logic covered);
        exp_q.push_back(b);
        if (covered)
            run_crc = crc_byte(run_crc, b);
    endtask

    // walk the records and build the expected byte list
    task automatic load_patterns;
        int          p;
        int          n;
        logic [63:0] ctl;
        mac_addr_t   dst;
        mac_addr_t   src;
        mac_addr_t   dsel;
        int          gap;
        fcs_t        fcs;
        p   = 0;
        n   = 0;
        dst = DEFAULT_DST_MAC;
        src = DEFAULT_SRC_MAC;
        gap = int'(DEFAULT_IPG);
        while (pat_mem[p] != 64'h0 && n < MAX_FRAMES)
        begin
            ctl        = pat_mem[p];
            p          = p + 1;
            f_type[n]  = ctl[63:48];
            f_flags[n] = ctl[39:32];
            f_len[n]   = int'(ctl[15:0]);
            if (ctl[32])
            begin
                dst = pat_mem[p][47:0];
                p   = p + 1;
            end
            if (ctl[33])
            begin
                src = pat_mem[p][47:0];
                p   = p + 1;
            end
            if (ctl[34])
                gap = int'(ctl[47:40]);
            f_gap[n] = gap;
            f_pay[n] = p;
            // preamble and sfd lie outside the fcs
            for (int i = 0; i < PREAMBLE_LEN; i++)
                emit(PREAMBLE_BYTE, 1'b0);
            emit(SFD_BYTE, 1'b0);
            run_crc = CRC_INIT;
            dsel    = (f_type[n] == ETHERTYPE_ARP) ? BROADCAST_MAC : dst;
            // header fields msb first
            for (int i = 0; i < 6; i++)
                emit(dsel[8*(5-i) +: 8], 1'b1);
            for (int i = 0; i < 6; i++)
                emit(src[8*(5-i) +: 8], 1'b1);
            emit(f_type[n][15:8], 1'b1);
            emit(f_type[n][7:0], 1'b1);
            for (int i = 0; i < f_len[n]; i++)
                emit(pat_mem[p+i][7:0], 1'b1);
            // fcs lsb first
            fcs = ~run_crc;
            for (int i = 0; i < FCS_LEN; i++)
                emit(fcs[8*i +: 8], 1'b0);
            f_end[n] = exp_q.size() - 1;
            p        = p + f_len[n];
            n        = n + 1;
        end
        nframes = n;
        limit   = 40 * exp_q.size() + 1000;
    endtask

    // compare and stop on the first mismatch
    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "output mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    // config loads wait until every earlier frame has left
    task automatic send_frame(input int k);
        int ctl_at;
        ctl_at = f_pay[k] - 1 - int'(f_flags[k][0]) - int'(f_flags[k][1]);
        if (f_flags[k][2:0] != 3'b000)
        begin
            wait (o_frame_cnt == frame_cnt_t'(k));
            @(posedge i_clk);
            #1;
            i_dst_mac       = pat_mem[ctl_at + 1][47:0];
            i_dst_mac_valid = f_flags[k][0];
            i_src_mac       = pat_mem[f_pay[k] - 1][47:0];
            i_src_mac_valid = f_flags[k][1];
            i_ipg           = pat_mem[ctl_at][47:40];
            i_ipg_valid     = f_flags[k][2];
            @(posedge i_clk);
            #1;
            i_dst_mac_valid = 1'b0;
            i_src_mac_valid = 1'b0;
            i_ipg_valid     = 1'b0;
        end
        i_s_type = f_type[k];
        for (int i = 0; i < f_len[k]; i++)
        begin
            i_s_valid = 1'b1;
            i_s_data  = pat_mem[f_pay[k] + i][7:0];
            i_s_last  = (i == f_len[k] - 1);
            // transfer on the next edge once ready is seen
            @(negedge i_clk);
            while (!o_s_ready)
                @(negedge i_clk);
            @(posedge i_clk);
            #1;
        end
        i_s_valid = 1'b0;
        i_s_last  = 1'b0;
    endtask

    // sink ready is random only for throttled frames
    always @(posedge i_clk)
    begin
        #1;
        if (mon_frame < nframes && f_flags[mon_frame][3])
            i_m_ready = (($random(seed) & 3) != 0);
        else
            i_m_ready = 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // output monitor sampled mid-cycle
    always @(negedge i_clk)
    begin
        if (!i_rst)
        begin
            if (cnt_pending)
            begin
                check("frame count", mon_frame, 32'(o_frame_cnt));
                cnt_pending = 1'b0;
            end
            if (o_m_valid)
            begin
                if (mon_frame >= nframes)
                    check("extra output beat", 0, 1);
                // stalled beat must not move
                if (prev_stall)
                begin
                    check("hold data", prev_data, o_m_data);
                    check("hold last", prev_last, o_m_last);
                end
                if (pos_in_frame == 0 && mon_frame > 0)
                    check($sformatf("gap before frame %0d", mon_frame), 1,
                          32'(idle_cnt >= f_gap[mon_frame]));
                if (i_m_ready)
                begin
                    check($sformatf("frame %0d byte %0d", mon_frame, pos_in_frame),
                          exp_q[exp_idx], o_m_data);
                    check($sformatf("frame %0d last %0d", mon_frame, pos_in_frame),
                          32'(exp_idx == f_end[mon_frame]), o_m_last);
                    exp_idx      = exp_idx + 1;
                    pos_in_frame = pos_in_frame + 1;
                    if (o_m_last)
                    begin
                        mon_frame    = mon_frame + 1;
                        pos_in_frame = 0;
                        idle_cnt     = 0;
                        cnt_pending  = 1'b1;
                    end
                end
                prev_stall = !i_m_ready;
                prev_data  = o_m_data;
                prev_last  = o_m_last;
            end
            else
            begin
                idle_cnt   = idle_cnt + 1;
                prev_stall = 1'b0;
            end
        end
    end

    // run limit from the total byte count
    always @(posedge i_clk)
    begin
        cycles = cycles + 1;
        if (cycles > limit)
        begin
            $display("timeout: frames still missing after %0d cycles", limit);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        i_clk           = 1'b0;
        i_rst           = 1'b1;
        i_s_valid       = 1'b0;
        i_s_data        = '0;
        i_s_last        = 1'b0;
        i_s_type        = '0;
        i_dst_mac       = '0;
        i_dst_mac_valid = 1'b0;
        i_src_mac       = '0;
        i_src_mac_valid = 1'b0;
        i_ipg           = '0;
        i_ipg_valid     = 1'b0;
        i_m_ready       = 1'b1;
        seed            = 32'hb388_3883;
        mon_frame       = 0;
        exp_idx         = 0;
        pos_in_frame    = 0;
        idle_cnt        = 0;
        prev_stall      = 1'b0;
        prev_data       = '0;
        prev_last       = 1'b0;
        cnt_pending     = 1'b0;
        cycles          = 0;
        limit           = 1000;
        for (int i = 0; i < PAT_WORDS; i++)
            pat_mem[i] = 64'h0;
        $readmemh("dv/eth_tx_patterns.hex", pat_mem);
        load_patterns();
        if (nframes == 0)
        begin
            $display("no frame records found in the pattern file");
            $display("tests failed");
            $fatal(1, "empty pattern file");
        end
        repeat (10) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        check("ready after reset", 1, 32'(o_s_ready));
        check("valid after reset", 0, 32'(o_m_valid));
        check("count after reset", 0, 32'(o_frame_cnt));
        for (int k = 0; k < nframes; k++)
            send_frame(k);
        wait (mon_frame == nframes);
        @(negedge i_clk);
        check("final frame count", nframes, 32'(o_frame_cnt));
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== dv/eth_tx_patterns.hex ====
// control: type[63:48] gap[47:40] flags[39:32] len[15:0], then dst, src, payload
// flags: bit0 load dst, bit1 load src, bit2 load gap, bit3 throttle sink
0800000000000004
11 22 33 44
0806000000000003
AA BB CC
0800140F00000005
00000A0B0C0D0E0F
0000021122334455
01 02 03 04 05
86DD000800000002
DE AD
0806000800000003
5A A5 0F
0800000800000006
10 20 30 40 50 60
0000000000000000

// ==== rtl/crc32_d8.sv ====
`timescale 1ns/10ps

module crc32_d8
(
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_init,
    input  logic                 i_en,
    input  eth_frame_pkg::byte_t i_data,
    output eth_frame_pkg::fcs_t  o_crc
);
    import eth_frame_pkg::*;

    fcs_t crc_q;

    // one octet, lsb first, against the reversed polynomial
    function automatic fcs_t crc_next(input fcs_t crc, input byte_t data);
        fcs_t poly_r;
        fcs_t c;
        for (int i = 0; i < $bits(fcs_t); i++)
        begin
            poly_r[i] = CRC_POLY[$bits(fcs_t) - 1 - i];
        end
        c = crc ^ fcs_t'(data);
        for (int b = 0; b < 8; b++)
        begin
            // shift out one bit, fold poly back on a one
            if (c[0])
                c = (c >> 1) ^ poly_r;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    // init wins over a same-cycle enable
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            crc_q <= CRC_INIT;
        else if (i_init)
            crc_q <= CRC_INIT;
        else if (i_en)
            crc_q <= crc_next(crc_q, i_data);
    end

    // raw register, not complemented
    assign o_crc = crc_q;

endmodule

// ==== rtl/eth_byte_if.sv ====
`timescale 1ns/10ps

// byte stream with valid/ready handshake
interface eth_byte_if;
    import eth_frame_pkg::*;

    logic  valid;
    logic  ready;
    byte_t data;
    // final byte of the unit on this link
    logic  last;

    // producer side
    modport src
    (
        output valid,
        output data,
        output last,
        input  ready
    );

    // consumer side, ready may follow valid
    modport snk
    (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

// ==== rtl/eth_frame_builder.sv ====
`timescale 1ns/10ps

module eth_frame_builder
(
    input  logic                       i_clk,
    input  logic                       i_rst,
    eth_byte_if.snk                    i_pay,
    input  logic                       i_desc_valid,
    input  eth_frame_pkg::ether_type_t i_desc_type,
    output logic                       o_desc_ready,
    input  eth_frame_pkg::mac_addr_t   i_dst_mac,
    input  logic                       i_dst_mac_valid,
    input  eth_frame_pkg::mac_addr_t   i_src_mac,
    input  logic                       i_src_mac_valid,
    eth_byte_if.src                    o_frm
);
    import eth_frame_pkg::*;
    import eth_tx_cfg_pkg::*;

    // last index inside each multi-byte field
    localparam int MAC_LAST  = $bits(mac_addr_t) / 8 - 1;
    localparam int TYPE_LAST = $bits(ether_type_t) / 8 - 1;

    build_state_t state_q;
    logic [2:0]   idx_q;
    mac_addr_t    dst_mac_q;
    mac_addr_t    src_mac_q;
    ether_type_t  type_q;
    mac_addr_t    dst_sel;
    fcs_t         crc;
    fcs_t         fcs_n;
    byte_t        frm_data;
    logic         desc_take;
    logic         beat;
    logic         crc_en;

    ////////////////////////////////////////////////////////////////////////////
    // address registers
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            dst_mac_q <= DEFAULT_DST_MAC;
            src_mac_q <= DEFAULT_SRC_MAC;
        end
        else
        begin
            if (i_dst_mac_valid)
                dst_mac_q <= i_dst_mac;
            if (i_src_mac_valid)
                src_mac_q <= i_src_mac;
        end
    end

    // descriptor taken only when idle
    assign o_desc_ready = (state_q == IDLE);
    assign desc_take    = i_desc_valid && o_desc_ready;

    always_ff @(posedge i_clk)
    begin
        if (desc_take)
            type_q <= i_desc_type;
    end

    // arp overrides the programmed destination
    assign dst_sel = (type_q == ETHERTYPE_ARP) ? BROADCAST_MAC : dst_mac_q;
    assign fcs_n   = ~crc;

    ////////////////////////////////////////////////////////////////////////////
    // output byte select
    always_comb
    begin
        case (state_q)
            SFD:
                frm_data = SFD_BYTE;
            // mac and type go msb first
            DST:
                frm_data = dst_sel[8*(MAC_LAST - idx_q) +: 8];
            SRC:
                frm_data = src_mac_q[8*(MAC_LAST - idx_q) +: 8];
            TYPE:
                frm_data = type_q[8*(TYPE_LAST - idx_q) +: 8];
            PAYLOAD:
                frm_data = i_pay.data;
            // fcs goes lsb first
            FCS:
                frm_data = fcs_n[8*idx_q[1:0] +: 8];
            default:
                frm_data = PREAMBLE_BYTE;
        endcase
    end

    // payload valid/ready pass straight through
    assign o_frm.valid = (state_q != IDLE) && ((state_q != PAYLOAD) || i_pay.valid);
    assign o_frm.data  = frm_data;
    assign o_frm.last  = (state_q == FCS) && (idx_q == 3'(FCS_LEN - 1));
    assign i_pay.ready = (state_q == PAYLOAD) && o_frm.ready;
    assign beat        = o_frm.valid && o_frm.ready;

    // covered span is dst mac through last payload byte
    assign crc_en = beat && (state_q inside {DST, SRC, TYPE, PAYLOAD});

    crc32_d8 u_crc32_d8
    (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_init (desc_take),
        .i_en   (crc_en),
        .i_data (frm_data),
        .o_crc  (crc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // sequencer advancing on accepted beats only
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            state_q <= IDLE;
            idx_q   <= '0;
        end
        else if (desc_take)
        begin
            state_q <= PREAMBLE;
            idx_q   <= '0;
        end
        else if (beat)
        begin
            idx_q <= idx_q + 1'b1;
            case (state_q)
                PREAMBLE:
                    if (idx_q == 3'(PREAMBLE_LEN - 1))
                        state_q <= SFD;
                SFD:
                begin
                    state_q <= DST;
                    idx_q   <= '0;
                end
                DST:
                    if (idx_q == 3'(MAC_LAST))
                    begin
                        state_q <= SRC;
                        idx_q   <= '0;
                    end
                SRC:
                    if (idx_q == 3'(MAC_LAST))
                    begin
                        state_q <= TYPE;
                        idx_q   <= '0;
                    end
                TYPE:
                    if (idx_q == 3'(TYPE_LAST))
                        state_q <= PAYLOAD;
                // length comes from the payload last flag
                PAYLOAD:
                    if (i_pay.last)
                        state_q <= FCS;
                FCS:
                    if (o_frm.last)
                        state_q <= IDLE;
                default:
                    state_q <= IDLE;
            endcase
            // idx restarts for every field entry below
            if ((state_q == PREAMBLE && idx_q == 3'(PREAMBLE_LEN - 1))
                || (state_q == TYPE && idx_q == 3'(TYPE_LAST))
                || state_q == PAYLOAD)
                idx_q <= '0;
        end
    end

endmodule

// ==== rtl/eth_frame_pkg.sv ====
package eth_frame_pkg;

    // octet-level field types
    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] ether_type_t;
    typedef logic [31:0] fcs_t;

    ////////////////////////////////////////////////////////////////////////////
    // preamble and start-frame delimiter
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam int    PREAMBLE_LEN  = 7;
    localparam byte_t SFD_BYTE      = 8'hD5;

    // arp frames always go out as broadcast
    localparam ether_type_t ETHERTYPE_ARP = 16'h0806;
    localparam mac_addr_t   BROADCAST_MAC = 48'hFFFF_FFFF_FFFF;

    ////////////////////////////////////////////////////////////////////////////
    // crc-32, normal form here, bit-reversed where it is used
    localparam fcs_t CRC_POLY = 32'h04C1_1DB7;
    localparam fcs_t CRC_INIT = 32'hFFFF_FFFF;
    localparam int   FCS_LEN  = 4;

    // builder sequence, in wire order
    typedef enum logic [2:0] {
        IDLE, PREAMBLE, SFD, DST, SRC, TYPE, PAYLOAD, FCS
    } build_state_t;

endpackage

// ==== rtl/eth_mac_tx.sv ====
`timescale 1ns/10ps

module eth_mac_tx
(
    input  logic                       i_clk,
    input  logic                       i_rst,
    // payload in
    input  logic                       i_s_valid,
    output logic                       o_s_ready,
    input  eth_frame_pkg::byte_t       i_s_data,
    input  logic                       i_s_last,
    input  eth_frame_pkg::ether_type_t i_s_type,
    // run-time settings
    input  eth_frame_pkg::mac_addr_t   i_dst_mac,
    input  logic                       i_dst_mac_valid,
    input  eth_frame_pkg::mac_addr_t   i_src_mac,
    input  logic                       i_src_mac_valid,
    input  eth_tx_cfg_pkg::ipg_t       i_ipg,
    input  logic                       i_ipg_valid,
    // frame out
    output logic                       o_m_valid,
    input  logic                       i_m_ready,
    output eth_frame_pkg::byte_t       o_m_data,
    output logic                       o_m_last,
    output eth_tx_cfg_pkg::frame_cnt_t o_frame_cnt
);
    import eth_frame_pkg::*;

    // buffer to builder, builder to output stage
    eth_byte_if pay_if ();
    eth_byte_if frm_if ();

    logic        desc_valid;
    logic        desc_ready;
    ether_type_t desc_type;

    tx_frame_buffer u_tx_frame_buffer
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_s_valid    (i_s_valid),
        .o_s_ready    (o_s_ready),
        .i_s_data     (i_s_data),
        .i_s_last     (i_s_last),
        .i_s_type     (i_s_type),
        .o_pay        (pay_if.src),
        .o_desc_valid (desc_valid),
        .o_desc_type  (desc_type),
        .i_desc_ready (desc_ready)
    );

    eth_frame_builder u_eth_frame_builder
    (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_pay           (pay_if.snk),
        .i_desc_valid    (desc_valid),
        .i_desc_type     (desc_type),
        .o_desc_ready    (desc_ready),
        .i_dst_mac       (i_dst_mac),
        .i_dst_mac_valid (i_dst_mac_valid),
        .i_src_mac       (i_src_mac),
        .i_src_mac_valid (i_src_mac_valid),
        .o_frm           (frm_if.src)
    );

    tx_gap_ctrl u_tx_gap_ctrl
    (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_frm       (frm_if.snk),
        .i_ipg       (i_ipg),
        .i_ipg_valid (i_ipg_valid),
        .o_m_valid   (o_m_valid),
        .i_m_ready   (i_m_ready),
        .o_m_data    (o_m_data),
        .o_m_last    (o_m_last),
        .o_frame_cnt (o_frame_cnt)
    );

endmodule

// ==== rtl/eth_tx_cfg_pkg.sv ====
package eth_tx_cfg_pkg;

    // payload store, fill count is one bit wider than the address
    localparam int PAYLOAD_FIFO_DEPTH = 2048;
    localparam int PAYLOAD_PTR_W      = 12;

    // room reserved before a frame is let in
    localparam int MAX_FRAME_BYTES = 1518;

    // ethertype descriptor queue
    localparam int DESC_FIFO_DEPTH = 4;
    localparam int DESC_PTR_W      = 2;

    ////////////////////////////////////////////////////////////////////////////
    // run-time registers and their reset values
    typedef logic [7:0] ipg_t;
    localparam ipg_t DEFAULT_IPG = 8'd12;

    localparam eth_frame_pkg::mac_addr_t DEFAULT_DST_MAC = 48'h0000_00FF_FFFF;
    localparam eth_frame_pkg::mac_addr_t DEFAULT_SRC_MAC = 48'hFFFF_FF00_0000;

    // transmitted frames, wraps
    typedef logic [15:0] frame_cnt_t;

endpackage

// ==== rtl/tx_frame_buffer.sv ====
`timescale 1ns/10ps

module tx_frame_buffer
(
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_s_valid,
    output logic                      o_s_ready,
    input  eth_frame_pkg::byte_t      i_s_data,
    input  logic                      i_s_last,
    input  eth_frame_pkg::ether_type_t i_s_type,
    eth_byte_if.src                   o_pay,
    output logic                      o_desc_valid,
    output eth_frame_pkg::ether_type_t o_desc_type,
    input  logic                      i_desc_ready
);
    import eth_frame_pkg::*;
    import eth_tx_cfg_pkg::*;

    // payload store, {last, data} per entry
    logic [8:0]               pay_mem [0:PAYLOAD_FIFO_DEPTH-1];
    logic [PAYLOAD_PTR_W-2:0] pay_wr_ptr;
    logic [PAYLOAD_PTR_W-2:0] pay_rd_ptr;
    logic [PAYLOAD_PTR_W-1:0] pay_count;
    logic                     pay_wr;
    logic                     pay_rd;

    // ethertype queue, one entry per complete frame
    ether_type_t           desc_mem [0:DESC_FIFO_DEPTH-1];
    logic [DESC_PTR_W-1:0] desc_wr_ptr;
    logic [DESC_PTR_W-1:0] desc_rd_ptr;
    logic [DESC_PTR_W:0]   desc_count;
    logic                  desc_push;
    logic                  desc_pop;

    // set after the first beat, cleared by the last
    logic        in_frame;
    ether_type_t type_q;
    logic        room_ok;

    ////////////////////////////////////////////////////////////////////////////
    // input side

    // a full frame of space is claimed at its first beat
    assign room_ok   = (pay_count <= PAYLOAD_FIFO_DEPTH - MAX_FRAME_BYTES)
                     && (desc_count < DESC_FIFO_DEPTH);
    assign o_s_ready = in_frame || room_ok;
    assign pay_wr    = i_s_valid && o_s_ready;
    // push only once the frame is whole
    assign desc_push = pay_wr && i_s_last;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            in_frame <= 1'b0;
        else if (pay_wr)
            in_frame <= !i_s_last;
    end

    always_ff @(posedge i_clk)
    begin
        if (pay_wr)
            pay_mem[pay_wr_ptr] <= {i_s_last, i_s_data};
        if (pay_wr && !in_frame)
            type_q <= i_s_type;
        // single-beat frame takes the type straight from the port
        if (desc_push)
            desc_mem[desc_wr_ptr] <= in_frame ? type_q : i_s_type;
    end

    ////////////////////////////////////////////////////////////////////////////
    // output side, both queues read without latency
    assign o_pay.valid  = (pay_count != '0);
    assign o_pay.data   = pay_mem[pay_rd_ptr][7:0];
    assign o_pay.last   = pay_mem[pay_rd_ptr][8];
    assign pay_rd       = o_pay.valid && o_pay.ready;

    assign o_desc_valid = (desc_count != '0);
    assign o_desc_type  = desc_mem[desc_rd_ptr];
    assign desc_pop     = o_desc_valid && i_desc_ready;

    // pointers and fill counts
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            pay_wr_ptr  <= '0;
            pay_rd_ptr  <= '0;
            pay_count   <= '0;
            desc_wr_ptr <= '0;
            desc_rd_ptr <= '0;
            desc_count  <= '0;
        end
        else
        begin
            if (pay_wr)
                pay_wr_ptr <= pay_wr_ptr + 1'b1;
            if (pay_rd)
                pay_rd_ptr <= pay_rd_ptr + 1'b1;
            pay_count <= pay_count + PAYLOAD_PTR_W'(pay_wr) - PAYLOAD_PTR_W'(pay_rd);
            if (desc_push)
                desc_wr_ptr <= desc_wr_ptr + 1'b1;
            if (desc_pop)
                desc_rd_ptr <= desc_rd_ptr + 1'b1;
            desc_count <= desc_count + (DESC_PTR_W+1)'(desc_push)
                        - (DESC_PTR_W+1)'(desc_pop);
        end
    end

endmodule

// ==== rtl/tx_gap_ctrl.sv ====
`timescale 1ns/10ps

module tx_gap_ctrl
(
    input  logic                       i_clk,
    input  logic                       i_rst,
    eth_byte_if.snk                    i_frm,
    input  eth_tx_cfg_pkg::ipg_t       i_ipg,
    input  logic                       i_ipg_valid,
    output logic                       o_m_valid,
    input  logic                       i_m_ready,
    output eth_frame_pkg::byte_t       o_m_data,
    output logic                       o_m_last,
    output eth_tx_cfg_pkg::frame_cnt_t o_frame_cnt
);
    import eth_tx_cfg_pkg::*;

    ipg_t ipg_q;
    ipg_t gap_cnt;
    logic gap_busy;
    logic gap_hold;
    logic out_free;
    logic load;
    logic last_done;

    ////////////////////////////////////////////////////////////////////////////
    // output register stage

    // a held last byte never drains into the next frame
    assign out_free    = !o_m_valid || (i_m_ready && !o_m_last);
    assign gap_hold    = gap_busy && (gap_cnt < ipg_q);
    assign i_frm.ready = out_free && !gap_hold;
    assign load        = i_frm.valid && i_frm.ready;
    assign last_done   = o_m_valid && i_m_ready && o_m_last;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            o_m_valid <= 1'b0;
            o_m_last  <= 1'b0;
        end
        else if (load)
        begin
            o_m_valid <= 1'b1;
            o_m_last  <= i_frm.last;
        end
        else if (i_m_ready)
            o_m_valid <= 1'b0;
    end

    always_ff @(posedge i_clk)
    begin
        if (load)
            o_m_data <= i_frm.data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // inter-packet gap and frame count
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            ipg_q       <= DEFAULT_IPG;
            gap_cnt     <= '0;
            gap_busy    <= 1'b0;
            o_frame_cnt <= '0;
        end
        else
        begin
            if (i_ipg_valid)
                ipg_q <= i_ipg;
            // count idle cycles from the accepted last byte
            if (last_done)
            begin
                gap_busy    <= 1'b1;
                gap_cnt     <= '0;
                o_frame_cnt <= o_frame_cnt + 1'b1;
            end
            else if (gap_busy)
            begin
                if (gap_hold)
                    gap_cnt <= gap_cnt + 1'b1;
                else
                    gap_busy <= 1'b0;
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench, pass only when the pass line is printed
verilator --binary -f sim.f --top-module eth_mac_tx_tb -o eth_mac_tx_sim \
    && ./obj_dir/eth_mac_tx_sim | grep -q "all tests passed" \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }

// ==== sim.f ====
rtl/eth_frame_pkg.sv
rtl/eth_tx_cfg_pkg.sv
rtl/eth_byte_if.sv
rtl/tx_frame_buffer.sv
rtl/crc32_d8.sv
rtl/eth_frame_builder.sv
rtl/tx_gap_ctrl.sv
rtl/eth_mac_tx.sv
dv/eth_mac_tx_tb.sv
